// ==== Bender.yml ====
package:
  name: stream_count

export_include_dirs:
  - common

sources:
  - common/stream_count_pkg.sv
  - stream_fifo/stream_fifo.sv
  - transfer_counter/transfer_counter.sv
  - rtl/stream_count_top.sv
  - target: test
    files:
      - tests/stream_count_chk.sv
      - tests/stream_count_tb.sv

// ==== common/stream_count_params.svh ====
`ifndef STREAM_COUNT_PARAMS_SVH
`define STREAM_COUNT_PARAMS_SVH

// width of one stream data word.
`define STREAM_DATA_WIDTH 16

// number of words the fifo can hold.
`define STREAM_FIFO_DEPTH 16

// highest value either counter may reach.
// kept above the fifo depth so the word count never clamps in normal use.
`define STREAM_COUNT_MAX 32

`endif

// ==== common/stream_count_pkg.sv ====
`include "stream_count_params.svh"

package stream_count_pkg;

    // fifo pointer width.
    localparam int fifo_addr_width = (`STREAM_FIFO_DEPTH > 1) ?
        $clog2(`STREAM_FIFO_DEPTH) : 1;

    // bits to hold zero up to the counter maximum inclusive.
    localparam int count_width = (`STREAM_COUNT_MAX >= 2) ?
        $clog2(`STREAM_COUNT_MAX + 1) : 2;

    // count stream data, rounded to whole bytes.
    localparam int count_data_width = 8 * ((count_width + 7) / 8);

endpackage

// ==== project.f ====
+incdir+common
common/stream_count_pkg.sv
stream_fifo/stream_fifo.sv
transfer_counter/transfer_counter.sv
rtl/stream_count_top.sv
tests/stream_count_chk.sv
tests/stream_count_tb.sv

// ==== rtl/stream_count_top.sv ====
`timescale 1ns/1ps

`include "stream_count_params.svh"

module stream_count_top (
    input  logic                                          aclk,
    input  logic                                          areset_n,
    input  logic                                          rx_tvalid,
    input  logic [`STREAM_DATA_WIDTH-1:0]                 rx_tdata,
    input  logic                                          rx_tlast,
    output logic                                          rx_tready,
    output logic                                          tx_tvalid,
    output logic [`STREAM_DATA_WIDTH-1:0]                 tx_tdata,
    output logic                                          tx_tlast,
    input  logic                                          tx_tready,
    output logic                                          word_count_tvalid,
    output logic [stream_count_pkg::count_data_width-1:0] word_count_tdata,
    input  logic                                          word_count_tready,
    output logic                                          packet_count_tvalid,
    output logic [stream_count_pkg::count_data_width-1:0] packet_count_tdata,
    input  logic                                          packet_count_tready
);

    // the buffer under watch.
    stream_fifo fifo_i (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tlast  (rx_tlast),
        .rx_tready (rx_tready),
        .tx_tvalid (tx_tvalid),
        .tx_tdata  (tx_tdata),
        .tx_tlast  (tx_tlast),
        .tx_tready (tx_tready)
    );

    // words held in the fifo.
    transfer_counter #(
        .COUNT_MAX (`STREAM_COUNT_MAX),
        .PACKETS   (0)
    ) word_counter_i (
        .aclk              (aclk),
        .areset_n          (areset_n),
        .monitor_rx_tvalid (rx_tvalid),
        .monitor_rx_tready (rx_tready),
        .monitor_rx_tlast  (rx_tlast),
        .monitor_tx_tvalid (tx_tvalid),
        .monitor_tx_tready (tx_tready),
        .monitor_tx_tlast  (tx_tlast),
        .count_tvalid      (word_count_tvalid),
        .count_tdata       (word_count_tdata),
        .count_tready      (word_count_tready)
    );

    // complete packets held in the fifo.
    transfer_counter #(
        .COUNT_MAX (`STREAM_COUNT_MAX),
        .PACKETS   (1)
    ) packet_counter_i (
        .aclk              (aclk),
        .areset_n          (areset_n),
        .monitor_rx_tvalid (rx_tvalid),
        .monitor_rx_tready (rx_tready),
        .monitor_rx_tlast  (rx_tlast),
        .monitor_tx_tvalid (tx_tvalid),
        .monitor_tx_tready (tx_tready),
        .monitor_tx_tlast  (tx_tlast),
        .count_tvalid      (packet_count_tvalid),
        .count_tdata       (packet_count_tdata),
        .count_tready      (packet_count_tready)
    );

endmodule

// ==== stream_fifo/stream_fifo.sv ====
`timescale 1ns/1ps

`include "stream_count_params.svh"

module stream_fifo (
    input  logic                          aclk,
    input  logic                          areset_n,
    input  logic                          rx_tvalid,
    input  logic [`STREAM_DATA_WIDTH-1:0] rx_tdata,
    input  logic                          rx_tlast,
    output logic                          rx_tready,
    output logic                          tx_tvalid,
    output logic [`STREAM_DATA_WIDTH-1:0] tx_tdata,
    output logic                          tx_tlast,
    input  logic                          tx_tready
);
    import stream_count_pkg::*;

    localparam int DEPTH = `STREAM_FIFO_DEPTH;
    localparam int ENTRY_WIDTH = `STREAM_DATA_WIDTH + 1;

    localparam logic [fifo_addr_width-1:0] LAST_ADDR = fifo_addr_width'(DEPTH - 1);
    localparam logic [fifo_addr_width:0] FULL_COUNT = (fifo_addr_width + 1)'(DEPTH);

    // each entry holds last in the top bit, data below it.
    logic [ENTRY_WIDTH-1:0] mem [DEPTH];

    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0] count;
    logic [fifo_addr_width:0] count_next;

    logic write;
    logic read;

    // handshakes, ready and valid are the registered flags.
    always_comb write = rx_tvalid && rx_tready;
    always_comb read = tx_tvalid && tx_tready;

    // occupancy after this edge.
    always_comb begin
        count_next = count;
        if (write && !read) begin
            count_next = count + 1'b1;
        end
        else if (!write && read) begin
            count_next = count - 1'b1;
        end
    end

    // storage array, written on each accepted word.
    always_ff @(posedge aclk) begin
        if (write) begin
            mem[wr_ptr] <= {rx_tlast, rx_tdata};
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
        end
        else if (write) begin
            // wrap explicitly, depth need not be a power of two.
            wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr <= '0;
        end
        else if (read) begin
            rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            count <= '0;
        end
        else begin
            count <= count_next;
        end
    end

    // flags follow the next occupancy.
    // so a word written into an empty fifo shows one cycle later.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
            tx_tvalid <= 1'b0;
        end
        else begin
            rx_tready <= (count_next != FULL_COUNT);
            tx_tvalid <= (count_next != '0);
        end
    end

    // head entry drives the output.
    always_comb tx_tdata = mem[rd_ptr][`STREAM_DATA_WIDTH-1:0];
    always_comb tx_tlast = mem[rd_ptr][ENTRY_WIDTH-1];

endmodule

// ==== tests/stream_count_chk.sv ====
`timescale 1ns/1ps

`include "stream_count_params.svh"

module stream_count_chk (
    input logic                                          aclk,
    input logic                                          areset_n,
    input logic                                          tx_tvalid,
    input logic [`STREAM_DATA_WIDTH-1:0]                 tx_tdata,
    input logic                                          tx_tlast,
    input logic                                          tx_tready,
    input logic                                          word_count_tvalid,
    input logic [stream_count_pkg::count_data_width-1:0] word_count_tdata,
    input logic                                          packet_count_tvalid
);
    import stream_count_pkg::*;

    // failed assertions, collected by the testbench.
    int failures = 0;

    // a stalled tx word holds until it is taken.
    tx_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        (tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast)))
        else begin
            $error("tx stream changed while stalled");
            failures++;
        end

    // count valids stay up once raised.
    word_valid_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        word_count_tvalid |=> word_count_tvalid)
        else begin
            $error("word_count_tvalid fell after rising");
            failures++;
        end

    packet_valid_hold: assert property (@(posedge aclk) disable iff (!areset_n)
        packet_count_tvalid |=> packet_count_tvalid)
        else begin
            $error("packet_count_tvalid fell after rising");
            failures++;
        end

    // word count is clamped at the counter maximum.
    word_count_bound: assert property (@(posedge aclk) disable iff (!areset_n)
        word_count_tdata <= count_data_width'(`STREAM_COUNT_MAX))
        else begin
            $error("word count above its maximum");
            failures++;
        end

endmodule

// ==== tests/stream_count_tb.sv ====
`timescale 1ns/1ps

`include "stream_count_params.svh"

module stream_count_tb;
    import stream_count_pkg::*;

    localparam int data_width = `STREAM_DATA_WIDTH;
    localparam int fifo_depth = `STREAM_FIFO_DEPTH;
    localparam int count_max = `STREAM_COUNT_MAX;
    localparam int random_cycles = 400;
    localparam string vector_file = "tests/stream_count_vectors.txt";

    logic aclk;
    logic areset_n;
    logic rx_tvalid;
    logic [data_width-1:0] rx_tdata;
    logic rx_tlast;
    logic rx_tready;
    logic tx_tvalid;
    logic [data_width-1:0] tx_tdata;
    logic tx_tlast;
    logic tx_tready;
    logic word_count_tvalid;
    logic [count_data_width-1:0] word_count_tdata;
    logic word_count_tready;
    logic packet_count_tvalid;
    logic [count_data_width-1:0] packet_count_tdata;
    logic packet_count_tready;

    // per cycle inputs as {valid, data, last, tx ready, word ready, packet ready}.
    logic [data_width+4:0] vec_in [$];
    int vec_words [$];
    int vec_packets [$];
    logic [data_width+4:0] rand_in;

    // accepted rx words in order, last flag on top.
    logic [data_width:0] expected_words [$];

    // reference model, mirrors the registered flags and counts.
    logic model_rx_ready;
    logic model_tx_valid;
    logic model_word_valid;
    logic model_packet_valid;
    int model_words;
    int model_packets;
    logic rx_accepted;

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = random_cycles + 100;

    stream_count_top stream_count_top_i (.*);

    bind stream_count_top stream_count_chk chk_i (.*);

    // 8 ns clock.
    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    // stops a run that never reaches its end.
    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout: no result after %0d clock cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // one counter step, clamped at zero and the maximum.
    function automatic int next_count(input int count, input logic up, input logic down);
        if (up && !down && count < count_max) begin
            return count + 1;
        end
        if (down && !up && count > 0) begin
            return count - 1;
        end
        return count;
    endfunction

    // comment and blank lines are skipped.
    task automatic load_vectors();
        int fd;
        string line;
        logic [31:0] f [6];
        int words;
        int packets;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], words, packets) == 8) begin
                vec_in.push_back({f[0][0], f[1][data_width-1:0], f[2][0], f[3][0], f[4][0],
                                  f[5][0]});
                vec_words.push_back(words);
                vec_packets.push_back(packets);
            end
        end
        $fclose(fd);
    endtask

    // starts and ends on a falling edge.
    task automatic run_cycle(input logic [data_width+4:0] stim);
        logic rx_hs;
        logic tx_hs;
        logic tx_pkt;
        logic [data_width:0] head;
        {rx_tvalid, rx_tdata, rx_tlast, tx_tready, word_count_tready, packet_count_tready} = stim;
        #1;
        compare_value("rx_tready", rx_tready, model_rx_ready);
        compare_value("tx_tvalid", tx_tvalid, model_tx_valid);
        rx_hs = rx_tvalid && model_rx_ready;
        tx_hs = model_tx_valid && tx_tready;
        tx_pkt = 1'b0;
        if (tx_hs && expected_words.size() == 0) begin
            $display("tx transfer at %0t while no accepted word is outstanding", $time);
            error_count++;
        end
        else if (tx_hs) begin
            head = expected_words.pop_front();
            tx_pkt = head[data_width];
            compare_value("tx_tdata", tx_tdata, head[data_width-1:0]);
            compare_value("tx_tlast", tx_tlast, head[data_width]);
        end
        if (rx_hs) begin
            expected_words.push_back({rx_tlast, rx_tdata});
        end
        // counts move only on edges where their own ready is high.
        if (word_count_tready) begin
            model_words = next_count(model_words, rx_hs, tx_hs);
            model_word_valid = 1'b1;
        end
        if (packet_count_tready) begin
            model_packets = next_count(model_packets, rx_hs && rx_tlast, tx_pkt);
            model_packet_valid = 1'b1;
        end
        model_rx_ready = (expected_words.size() != fifo_depth);
        model_tx_valid = (expected_words.size() != 0);
        rx_accepted = rx_hs;
        @(posedge aclk);
        #2;
        compare_value("word_count_tdata", word_count_tdata, model_words);
        compare_value("packet_count_tdata", packet_count_tdata, model_packets);
        compare_value("word_count_tvalid", word_count_tvalid, model_word_valid);
        compare_value("packet_count_tvalid", packet_count_tvalid, model_packet_valid);
        @(negedge aclk);
    endtask

    initial begin
        void'($urandom(4494));
        areset_n = 1'b0;
        {rx_tvalid, rx_tdata, rx_tlast, tx_tready, word_count_tready, packet_count_tready} = '0;
        {model_rx_ready, model_tx_valid, model_word_valid, model_packet_valid} = '0;
        model_words = 0;
        model_packets = 0;
        rx_accepted = 1'b0;
        load_vectors();
        cycle_limit = vec_in.size() + random_cycles + 100;
        if (vec_in.size() == 0) begin
            $display("no stimulus lines could be read from %s", vector_file);
            error_count++;
        end
        else begin
            repeat (8) @(posedge aclk);
            @(negedge aclk);
            // everything idle and zero while in reset.
            compare_value("rx_tready", rx_tready, 0);
            compare_value("tx_tvalid", tx_tvalid, 0);
            compare_value("word_count_tvalid", word_count_tvalid, 0);
            compare_value("packet_count_tvalid", packet_count_tvalid, 0);
            compare_value("word_count_tdata", word_count_tdata, 0);
            compare_value("packet_count_tdata", packet_count_tdata, 0);
            areset_n = 1'b1;
            for (int i = 0; i < vec_in.size(); i++) begin
                run_cycle(vec_in[i]);
                compare_value("word_count_tdata", word_count_tdata, vec_words[i]);
                compare_value("packet_count_tdata", packet_count_tdata, vec_packets[i]);
            end
            for (int i = 0; i < random_cycles; i++) begin
                // an offered word stays on the bus until taken.
                if (!rx_tvalid || rx_accepted) begin
                    rand_in[data_width+4] = ($urandom % 4) != 0;
                    rand_in[data_width+3:4] = data_width'($urandom);
                    rand_in[3] = ($urandom % 3) == 0;
                end
                // long tx back-pressure in the middle fills the fifo.
                if (i >= 150 && i < 280) begin
                    rand_in[2] = ($urandom % 5) == 0;
                end
                else begin
                    rand_in[2] = ($urandom % 4) != 0;
                end
                // late in the run tx reads go uncounted.
                // so the word count climbs to its clamp.
                if (i >= 300 && i < 380) begin
                    rand_in[1] = !(model_tx_valid && rand_in[2]);
                end
                else begin
                    rand_in[1] = ($urandom % 8) != 0;
                end
                rand_in[0] = ($urandom % 8) != 0;
                run_cycle(rand_in);
            end
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
                 stream_count_top_i.chk_i.failures);
        if (error_count == 0 && stream_count_top_i.chk_i.failures == 0) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/stream_count_vectors.txt ====
# rx_tvalid rx_tdata rx_tlast tx_tready word_count_tready packet_count_tready (hex)
# then expected word count and packet count after the next rising edge (decimal)
1 0101 0 0 1 1 0 0
1 0101 0 0 1 1 1 0
1 0102 1 0 1 1 2 1
1 0103 0 0 1 1 3 1
1 0104 1 0 1 1 4 2
0 0000 0 1 1 1 3 2
1 0105 0 1 1 1 3 1
1 0106 0 0 1 1 4 1
1 0107 1 0 1 1 5 2
1 0108 0 0 1 1 6 2
1 0109 0 0 1 1 7 2
1 010a 0 0 1 1 8 2
1 010b 1 0 1 1 9 3
1 010c 0 0 1 1 10 3
1 010d 0 0 1 1 11 3
1 010e 0 0 1 1 12 3
1 010f 1 0 1 1 13 4
1 0110 0 0 1 1 14 4
1 0111 0 0 1 1 15 4
1 0112 0 0 1 1 16 4
1 0113 1 0 1 1 16 4
1 0113 1 1 1 1 15 4
1 0113 1 0 1 1 16 5
0 0000 0 1 0 1 16 4
0 0000 0 1 1 0 15 4
1 0114 1 0 1 0 16 4
0 0000 0 1 1 1 15 4
0 0000 0 1 1 1 14 3
1 0115 0 1 1 1 14 3
1 0116 1 1 1 1 14 4
0 0000 0 0 0 0 14 4
0 0000 0 1 1 1 13 4
0 0000 0 1 1 1 12 3

// ==== transfer_counter/transfer_counter.sv ====
`timescale 1ns/1ps

`include "stream_count_params.svh"

module transfer_counter #(
    parameter int COUNT_MAX = `STREAM_COUNT_MAX,
    parameter int PACKETS = 0
) (
    input  logic                                          aclk,
    input  logic                                          areset_n,
    input  logic                                          monitor_rx_tvalid,
    input  logic                                          monitor_rx_tready,
    input  logic                                          monitor_rx_tlast,
    input  logic                                          monitor_tx_tvalid,
    input  logic                                          monitor_tx_tready,
    input  logic                                          monitor_tx_tlast,
    output logic                                          count_tvalid,
    output logic [stream_count_pkg::count_data_width-1:0] count_tdata,
    input  logic                                          count_tready
);
    import stream_count_pkg::*;

    localparam int COUNTER_WIDTH = (COUNT_MAX >= 2) ? $clog2(COUNT_MAX + 1) : 2;
    localparam logic [COUNTER_WIDTH-1:0] MAX_VALUE = COUNTER_WIDTH'(COUNT_MAX);
    localparam logic [COUNTER_WIDTH-1:0] ALMOST_EMPTY = COUNTER_WIDTH'(1);
    localparam logic [COUNTER_WIDTH-1:0] ALMOST_FULL = COUNTER_WIDTH'(COUNT_MAX - 1);

    logic write;
    logic read;
    logic [COUNTER_WIDTH-1:0] counter;
    logic [COUNTER_WIDTH-1:0] counter_next;

    logic empty;
    logic full;
    logic almost_empty;
    logic almost_full;

    // almost flags narrow the count to two values, low bit picks one.
    always_comb empty = almost_empty && (counter[0] == 1'b0);
    always_comb full = almost_full && (counter[0] == MAX_VALUE[0]);

    generate
        if (PACKETS > 0) begin : g_packets
            // only the closing word of a packet counts.
            always_comb write = monitor_rx_tvalid && monitor_rx_tready && monitor_rx_tlast;
            always_comb read = monitor_tx_tvalid && monitor_tx_tready && monitor_tx_tlast;
        end
        else begin : g_words
            always_comb write = monitor_rx_tvalid && monitor_rx_tready;
            always_comb read = monitor_tx_tvalid && monitor_tx_tready;
        end
    endgenerate

    // steps past either bound are dropped.
    always_comb begin
        counter_next = counter;
        if (write && !read && !full) begin
            counter_next = counter + 1'b1;
        end
        else if (!write && read && !empty) begin
            counter_next = counter - 1'b1;
        end
    end

    // everything below advances only while the count stream is taken.
    // transfers in stalled cycles are lost on purpose.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            counter <= '0;
        end
        else if (count_tready) begin
            counter <= counter_next;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            almost_empty <= 1'b1;
            almost_full <= (ALMOST_FULL == '0);
        end
        else if (count_tready) begin
            almost_empty <= (counter_next <= ALMOST_EMPTY);
            almost_full <= (counter_next >= ALMOST_FULL);
        end
    end

    // valid comes up on the first accepted beat and stays.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            count_tvalid <= 1'b0;
        end
        else if (count_tready) begin
            count_tvalid <= 1'b1;
        end
    end

    // zero-extended to whole bytes.
    always_comb count_tdata = count_data_width'(counter);

endmodule
